//--- host_read_chan.sv
`timescale 1ns/1ps

module host_read_chan import read_chan_pkg::*;
(
    input  logic clk,
    input  logic reset_n,

    // AFU read request stream
    input  logic afu_rd_req_valid,
    output logic afu_rd_req_ready,
    input  t_afu_rd_req afu_rd_req,

    // Read TLPs to the host
    output logic tx_rd_tlp_valid,
    input  logic tx_rd_tlp_ready,
    output t_rd_req_tlp tx_rd_tlp,

    // Completions from the host
    input  logic rx_cpl_valid,
    output logic rx_cpl_ready,
    input  t_cpl_beat rx_cpl,

    // Line responses to the AFU
    output logic afu_rd_rsp_valid,
    input  logic afu_rd_rsp_ready,
    output t_afu_rd_rsp afu_rd_rsp
);

    // All of the read channel logic lives in the generator
    rd_tlp_gen rd_tlp_gen_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .afu_rd_req_valid (afu_rd_req_valid),
        .afu_rd_req_ready (afu_rd_req_ready),
        .afu_rd_req       (afu_rd_req),
        .tx_rd_tlp_valid  (tx_rd_tlp_valid),
        .tx_rd_tlp_ready  (tx_rd_tlp_ready),
        .tx_rd_tlp        (tx_rd_tlp),
        .rx_cpl_valid     (rx_cpl_valid),
        .rx_cpl_ready     (rx_cpl_ready),
        .rx_cpl           (rx_cpl),
        .afu_rd_rsp_valid (afu_rd_rsp_valid),
        .afu_rd_rsp_ready (afu_rd_rsp_ready),
        .afu_rd_rsp       (afu_rd_rsp)
    );

endmodule

//--- list.f
read_chan_pkg.sv
req_fifo.sv
tag_allocator.sv
rd_tlp_gen.sv
host_read_chan.sv
tb_completer.sv
tb_host_read_chan.sv

//--- rd_tlp_gen.sv
`timescale 1ns/1ps

module rd_tlp_gen import read_chan_pkg::*;
(
    input  logic clk,
    input  logic reset_n,

    // Read requests from the AFU
    input  logic afu_rd_req_valid,
    output logic afu_rd_req_ready,
    input  t_afu_rd_req afu_rd_req,

    // Memory read TLPs toward the host
    output logic tx_rd_tlp_valid,
    input  logic tx_rd_tlp_ready,
    output t_rd_req_tlp tx_rd_tlp,

    // Completion stream from the host, may also carry other packet types
    input  logic rx_cpl_valid,
    output logic rx_cpl_ready,
    input  t_cpl_beat rx_cpl,

    // Line responses to the AFU
    output logic afu_rd_rsp_valid,
    input  logic afu_rd_rsp_ready,
    output t_afu_rd_rsp afu_rd_rsp
);

    // ======================================================================
    // Request buffering and tag allocation
    // ======================================================================

    t_afu_rd_req rd_req;
    logic rd_req_not_empty;
    logic rd_req_deq;

    // Lets the AFU keep streaming while a TLP waits for a tag or the link
    req_fifo req_fifo_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_data  (afu_rd_req),
        .enq_en    (afu_rd_req_valid && afu_rd_req_ready),
        .not_full  (afu_rd_req_ready),
        .first     (rd_req),
        .deq_en    (rd_req_deq),
        .not_empty (rd_req_not_empty)
    );

    logic tag_ready;
    logic [TAG_W-1:0] new_tag;
    logic free_tag;
    logic [TAG_W-1:0] free_tag_value;

    tag_allocator tag_allocator_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .alloc       (rd_req_deq),
        .alloc_ready (tag_ready),
        .alloc_tag   (new_tag),
        .free        (free_tag),
        .free_tag    (free_tag_value)
    );

    // A request leaves the FIFO only with a tag in hand and room in the TLP register
    assign rd_req_deq = rd_req_not_empty && tag_ready &&
                        (tx_rd_tlp_ready || !tx_rd_tlp_valid);

    // ======================================================================
    // Request metadata, indexed by PCIe tag
    // ======================================================================

    t_rd_meta rd_meta [NUM_TAGS];

    always_ff @(posedge clk)
    begin
        if (rd_req_deq)
        begin
            rd_meta[new_tag] <= '{afu_tag: rd_req.afu_tag, line_count: rd_req.line_count};
        end
    end

    // ======================================================================
    // Read request TLP
    // ======================================================================

    t_rd_req_tlp tlp_hdr;

    // Only whole lines are read, so both byte enables are always full
    always_comb
    begin
        tlp_hdr.fmttype = MEM_RD32;
        tlp_hdr.length = 10'(rd_req.line_count * LINE_DWORDS);
        tlp_hdr.tag = new_tag;
        tlp_hdr.last_be = 4'b1111;
        tlp_hdr.first_be = 4'b1111;
        tlp_hdr.addr = rd_req.addr;
    end

    // Output register, refilled whenever it is empty or being drained
    always_ff @(posedge clk)
    begin
        if (tx_rd_tlp_ready || !tx_rd_tlp_valid)
        begin
            tx_rd_tlp_valid <= rd_req_deq;
        end

        if (rd_req_deq)
        begin
            tx_rd_tlp <= tlp_hdr;
        end

        if (!reset_n)
        begin
            tx_rd_tlp_valid <= 1'b0;
        end
    end

    // ======================================================================
    // Completion decode
    // ======================================================================

    logic [TAG_W-1:0] cpl_tag;
    t_rd_meta cpl_meta;

    assign cpl_tag = rx_cpl.hdr.tag;
    assign cpl_meta = rd_meta[cpl_tag];

    // The response register gates the whole completion stream
    assign rx_cpl_ready = !afu_rd_rsp_valid || afu_rd_rsp_ready;

    // State of the packet in progress, carried from its sop beat
    logic reg_active;
    logic reg_is_last;
    logic [AFU_TAG_W-1:0] reg_afu_tag;
    t_line_idx reg_line_idx;
    logic [TAG_W-1:0] reg_pcie_tag;

    logic rsp_active;
    logic rsp_is_last;
    logic [AFU_TAG_W-1:0] rsp_afu_tag;
    t_line_idx rsp_line_idx;

    always_comb
    begin
        if (rx_cpl.sop)
        begin
            // Only completions with data produce lines, anything else is dropped
            rsp_active = (rx_cpl.hdr.fmttype == CPL_D);

            // Final packet of the request when it covers every byte still due
            // Its eop beat still has to be checked before flagging last
            rsp_is_last = (rx_cpl.hdr.byte_count[11:2] == rx_cpl.hdr.length);
            rsp_afu_tag = cpl_meta.afu_tag;

            // Lines already delivered equal total lines minus lines still due
            // This holds however the host splits the completion
            rsp_line_idx = t_line_idx'(cpl_meta.line_count -
                                       t_line_count'(rx_cpl.hdr.byte_count / LINE_BYTES));
        end
        else
        begin
            rsp_active = reg_active;
            rsp_is_last = reg_is_last;
            rsp_afu_tag = reg_afu_tag;
            rsp_line_idx = t_line_idx'(reg_line_idx + 1'b1);
        end

        // An idle cycle in the middle of a packet produces no line
        if (!rx_cpl_valid)
        begin
            rsp_active = 1'b0;
        end
    end

    // Remember packet state for the beats after sop
    always_ff @(posedge clk)
    begin
        if (rx_cpl_valid && rx_cpl_ready)
        begin
            reg_active <= rsp_active && !rx_cpl.eop;
            reg_is_last <= rsp_is_last;
            reg_afu_tag <= rsp_afu_tag;
            reg_line_idx <= rsp_line_idx;

            if (rx_cpl.sop)
            begin
                reg_pcie_tag <= cpl_tag;
            end
        end

        if (!reset_n)
        begin
            reg_active <= 1'b0;
        end
    end

    // ======================================================================
    // AFU response register
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (rx_cpl_ready)
        begin
            afu_rd_rsp_valid <= rsp_active;
            afu_rd_rsp.afu_tag <= rsp_afu_tag;
            afu_rd_rsp.line_idx <= rsp_line_idx;
            afu_rd_rsp.last <= rsp_is_last && rx_cpl.eop;
            afu_rd_rsp.payload <= rx_cpl.payload;
        end

        if (!reset_n)
        begin
            afu_rd_rsp_valid <= 1'b0;
        end
    end

    // The tag goes back to the pool once the final line is taken
    // No new sop can be accepted before that, so reg_pcie_tag still names it
    assign free_tag = afu_rd_rsp_valid && afu_rd_rsp_ready && afu_rd_rsp.last;
    assign free_tag_value = reg_pcie_tag;

endmodule

//--- read_cases.txt
# addr(hex) line_count afu_tag(hex) cpl_split hold
# cpl_split is the number of completion packets, hold=1 rows form one held group
00001000 1 01 1 0
00002040 4 02 2 0
00003100 3 03 3 0
00004000 2 04 1 0
00005000 4 10 4 1
00005200 1 11 1 1
00005400 2 12 2 1
00005600 3 13 2 1
00005800 4 14 1 1
00005a00 2 15 1 1
00005c00 1 16 1 1
00005e00 4 17 3 1
00006000 3 18 1 1
00006200 2 19 2 1
00007000 4 20 2 0
00007100 3 21 1 0
00007200 1 22 1 0
00007300 4 23 4 0
00007400 2 24 2 0
00007500 3 25 2 0

//--- read_chan_pkg.sv
package read_chan_pkg;

    // ======================================================================
    // Sizes of the read channel
    // ======================================================================

    // A line is the unit of data returned to the AFU on one beat
    localparam int LINE_BYTES = 16;
    localparam int LINE_DWORDS = 4;

    // Largest request the AFU may issue, counted in lines
    localparam int MAX_LINES = 4;

    // PCIe read tags in flight at once and the width needed to name them
    localparam int NUM_TAGS = 8;
    localparam int TAG_W = 3;

    // The AFU tag is opaque here and simply travels back with each line
    localparam int AFU_TAG_W = 8;
    localparam int ADDR_W = 32;

    // A line count runs 1 to MAX_LINES, so it needs one bit more than an index
    typedef logic [$clog2(MAX_LINES+1)-1:0] t_line_count;
    typedef logic [$clog2(MAX_LINES)-1:0] t_line_idx;

    // Format and type byte of the TLP header, PCIe encodings
    typedef enum logic [7:0] {
        MEM_RD32 = 8'h00,
        CPL      = 8'h0a,
        CPL_D    = 8'h4a
    } t_tlp_fmttype;

    // ======================================================================
    // Stream payloads
    // ======================================================================

    // Read request from the AFU
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        t_line_count line_count;
        logic [AFU_TAG_W-1:0] afu_tag;
    } t_afu_rd_req;

    // One line of read data back to the AFU
    typedef struct packed {
        logic [AFU_TAG_W-1:0] afu_tag;
        t_line_idx line_idx;
        logic last;
        logic [LINE_BYTES*8-1:0] payload;
    } t_afu_rd_rsp;

    // Memory read request header sent toward the host
    typedef struct packed {
        t_tlp_fmttype fmttype;
        logic [9:0] length;
        logic [TAG_W-1:0] tag;
        logic [3:0] last_be;
        logic [3:0] first_be;
        logic [ADDR_W-1:0] addr;
    } t_rd_req_tlp;

    // Completion header, byte_count counts the bytes still due including this packet
    typedef struct packed {
        t_tlp_fmttype fmttype;
        logic [TAG_W-1:0] tag;
        logic [9:0] length;
        logic [11:0] byte_count;
    } t_cpl_hdr;

    // One beat of the completion stream carries exactly one line
    typedef struct packed {
        logic sop;
        logic eop;
        t_cpl_hdr hdr;
        logic [LINE_BYTES*8-1:0] payload;
    } t_cpl_beat;

    // What must be remembered about a request while its tag is outstanding
    typedef struct packed {
        logic [AFU_TAG_W-1:0] afu_tag;
        t_line_count line_count;
    } t_rd_meta;

endpackage

//--- req_fifo.sv
`timescale 1ns/1ps

module req_fifo import read_chan_pkg::*;
(
    input  logic clk,
    input  logic reset_n,

    input  t_afu_rd_req enq_data,
    input  logic enq_en,
    output logic not_full,

    output t_afu_rd_req first,
    input  logic deq_en,
    output logic not_empty
);

    // Head entry drives first directly, the tail only holds the second request
    t_afu_rd_req head;
    t_afu_rd_req tail;

    // Number of valid entries, 0 to 2
    logic [1:0] count;

    assign first = head;
    assign not_empty = (count != 2'd0);
    assign not_full = (count != 2'd2);

    // Head loads from the tail when both are full, otherwise from the input
    // A dequeue of the only entry may load junk here, but count marks it empty
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            head <= (count == 2'd2) ? tail : enq_data;
        end
        else if (enq_en && (count == 2'd0))
        begin
            head <= enq_data;
        end

        // The tail fills when the new request cannot go straight to the head
        if (enq_en && (((count == 2'd1) && !deq_en) || ((count == 2'd2) && deq_en)))
        begin
            tail <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            count <= 2'd0;
        end
        else if (enq_en && !deq_en)
        begin
            count <= count + 2'd1;
        end
        else if (deq_en && !enq_en)
        begin
            count <= count - 2'd1;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the host read channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_host_read_chan -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_host_read_chan > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- tag_allocator.sv
`timescale 1ns/1ps

module tag_allocator import read_chan_pkg::*;
(
    input  logic clk,
    input  logic reset_n,

    // Allocation side, alloc_tag is only meaningful while alloc_ready is high
    input  logic alloc,
    output logic alloc_ready,
    output logic [TAG_W-1:0] alloc_tag,

    // Release side
    input  logic free,
    input  logic [TAG_W-1:0] free_tag
);

    // ======================================================================
    // Busy map, one bit per PCIe tag
    // ======================================================================

    logic [NUM_TAGS-1:0] busy;
    logic [NUM_TAGS-1:0] busy_next;

    // At least one tag is free whenever the map is not all ones
    assign alloc_ready = ~&busy;

    // Priority pick of the lowest free tag
    // Scanning downward lets the lowest index win the last assignment
    always_comb
    begin
        alloc_tag = '0;
        for (int i = NUM_TAGS - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                alloc_tag = TAG_W'(i);
            end
        end
    end

    // ======================================================================
    // Map update
    // ======================================================================

    // A free and an allocate can land in one cycle
    // They always name different tags since only a busy tag is ever freed
    always_comb
    begin
        busy_next = busy;

        if (free)
        begin
            busy_next[free_tag] = 1'b0;
        end

        if (alloc && alloc_ready)
        begin
            busy_next[alloc_tag] = 1'b1;
        end
    end

    // A tag freed at this edge shows up as available in the very next cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy <= '0;
        end
        else
        begin
            busy <= busy_next;
        end
    end

endmodule

//--- tb_completer.sv
`timescale 1ns/1ps

module tb_completer import read_chan_pkg::*;
(
    input  logic clk,
    input  logic reset_n,

    // Read TLPs from the DUT
    input  logic tx_rd_tlp_valid,
    output logic tx_rd_tlp_ready,
    input  t_rd_req_tlp tx_rd_tlp,

    // Completion stream to the DUT
    output logic rx_cpl_valid,
    input  logic rx_cpl_ready,
    output t_cpl_beat rx_cpl,

    // Split count of each accepted AFU request, in request order
    input  logic req_seen,
    input  logic [2:0] req_split,

    // While high no completion is sent and the backlog is answered newest first
    input  logic hold,
    output logic timed_out
);

    localparam int BEAT_LIMIT = 2000;
    localparam int IDLE_LIMIT = 20000;

    // Outstanding reads, one entry per queue position
    logic [ADDR_W-1:0] addr_q [$];
    int lines_q [$];
    logic [TAG_W-1:0] tag_q [$];
    int split_q [$];
    int split_pending_q [$];
    bit lifo;

    // Each dword of host memory holds its own byte address
    function automatic logic [127:0] line_payload(input logic [ADDR_W-1:0] addr, input int idx);
        logic [127:0] data;
        for (int k = 0; k < LINE_DWORDS; k++)
        begin
            data[32*k +: 32] = addr + 32'(LINE_BYTES * idx + 4 * k);
        end
        return data;
    endfunction

    initial
    begin
        tx_rd_tlp_ready = 1'b0;
    end

    always @(negedge clk)
    begin
        tx_rd_tlp_ready <= ($urandom % 4) != 0;
    end

    // TLPs leave the DUT in request order, so the split counts pair up in order
    always @(posedge clk)
    begin
        if (reset_n && req_seen)
        begin
            split_pending_q.push_back(int'(req_split));
        end
        if (reset_n && tx_rd_tlp_valid && tx_rd_tlp_ready)
        begin
            addr_q.push_back(tx_rd_tlp.addr);
            lines_q.push_back(int'(tx_rd_tlp.length) / LINE_DWORDS);
            tag_q.push_back(tx_rd_tlp.tag);
            split_q.push_back((split_pending_q.size() != 0) ? split_pending_q.pop_front() : 1);
        end
    end

    // ======================================================================
    // Completion sender
    // ======================================================================

    // Called on a falling edge, returns on the falling edge after the handshake
    task automatic send_beat(input logic sop, input logic eop, input t_tlp_fmttype fmt,
                             input logic [TAG_W-1:0] tag, input int dwords,
                             input int bytes_left, input logic [127:0] data);
        int waited;
        rx_cpl_valid = 1'b1;
        rx_cpl.sop = sop;
        rx_cpl.eop = eop;
        rx_cpl.hdr.fmttype = fmt;
        rx_cpl.hdr.tag = tag;
        rx_cpl.hdr.length = 10'(dwords);
        rx_cpl.hdr.byte_count = 12'(bytes_left);
        rx_cpl.payload = data;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
            if (waited > BEAT_LIMIT)
            begin
                timed_out = 1'b1;
            end
        end
        while (!rx_cpl_ready && !timed_out);
        @(negedge clk);
        rx_cpl_valid = 1'b0;
    endtask

    task automatic answer_next();
        int idx;
        int lines;
        int split;
        int line;
        int left;
        int n;
        logic [ADDR_W-1:0] addr;
        logic [TAG_W-1:0] tag;
        idx = lifo ? addr_q.size() - 1 : 0;
        addr = addr_q[idx];
        lines = lines_q[idx];
        tag = tag_q[idx];
        split = split_q[idx];
        addr_q.delete(idx);
        lines_q.delete(idx);
        tag_q.delete(idx);
        split_q.delete(idx);
        if (split < 1)
            split = 1;
        if (split > lines)
            split = lines;

        // A stray request packet with a random tag goes first
        send_beat(1'b1, 1'b1, MEM_RD32, TAG_W'($urandom), LINE_DWORDS, LINE_BYTES,
                  {$urandom, $urandom, $urandom, $urandom});

        // Earlier packets take one line more when the split is uneven
        line = 0;
        left = lines;
        for (int p = 0; p < split; p++)
        begin
            n = lines / split + ((p < lines % split) ? 1 : 0);
            for (int b = 0; b < n; b++)
            begin
                send_beat(b == 0, b == n - 1, CPL_D, tag, n * LINE_DWORDS,
                          left * LINE_BYTES, line_payload(addr, line + b));
            end
            line += n;
            left -= n;
        end
    endtask

    initial
    begin
        int idle;
        rx_cpl_valid = 1'b0;
        rx_cpl = '0;
        timed_out = 1'b0;
        lifo = 1'b0;
        idle = 0;
        forever
        begin
            @(negedge clk);
            if (addr_q.size() == 0)
                lifo = 1'b0;
            if (hold)
                lifo = 1'b1;
            if (reset_n && !hold && addr_q.size() != 0)
            begin
                idle = 0;
                answer_next();
            end
            else
            begin
                idle++;
                if (idle > IDLE_LIMIT)
                    timed_out = 1'b1;
            end
        end
    end

endmodule

//--- tb_host_read_chan.sv
`timescale 1ns/1ps

module tb_host_read_chan import read_chan_pkg::*;
();

    // Cycles any single wait may take before the run is declared stuck
    localparam int WAIT_LIMIT = 4000;

    logic clk;
    logic reset_n;
    logic afu_rd_req_valid;
    logic afu_rd_req_ready;
    t_afu_rd_req afu_rd_req;
    logic tx_rd_tlp_valid;
    logic tx_rd_tlp_ready;
    t_rd_req_tlp tx_rd_tlp;
    logic rx_cpl_valid;
    logic rx_cpl_ready;
    t_cpl_beat rx_cpl;
    logic afu_rd_rsp_valid;
    logic afu_rd_rsp_ready;
    t_afu_rd_rsp afu_rd_rsp;

    // Side band to the host model
    logic req_seen;
    logic [2:0] req_split;
    logic hold;
    logic cpl_timed_out;

    // Cases as read from the data file
    logic [ADDR_W-1:0] case_addr [64];
    int case_lines [64];
    int case_tag [64];
    int case_split [64];
    int case_hold [64];
    int num_cases;

    // Scoreboard, indexed by AFU tag, which is unique per case
    logic [ADDR_W-1:0] exp_addr [256];
    int exp_lines [256];
    int next_idx [256];
    bit tag_active [256];
    logic [TAG_W-1:0] pcie_of_afu [256];
    bit tag_busy [NUM_TAGS];
    int issued_afu_q [$];
    int tx_count;
    int rsp_count;

    host_read_chan host_read_chan_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .afu_rd_req_valid (afu_rd_req_valid),
        .afu_rd_req_ready (afu_rd_req_ready),
        .afu_rd_req       (afu_rd_req),
        .tx_rd_tlp_valid  (tx_rd_tlp_valid),
        .tx_rd_tlp_ready  (tx_rd_tlp_ready),
        .tx_rd_tlp        (tx_rd_tlp),
        .rx_cpl_valid     (rx_cpl_valid),
        .rx_cpl_ready     (rx_cpl_ready),
        .rx_cpl           (rx_cpl),
        .afu_rd_rsp_valid (afu_rd_rsp_valid),
        .afu_rd_rsp_ready (afu_rd_rsp_ready),
        .afu_rd_rsp       (afu_rd_rsp)
    );

    assign req_seen = afu_rd_req_valid && afu_rd_req_ready;

    tb_completer completer_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .tx_rd_tlp_valid (tx_rd_tlp_valid),
        .tx_rd_tlp_ready (tx_rd_tlp_ready),
        .tx_rd_tlp       (tx_rd_tlp),
        .rx_cpl_valid    (rx_cpl_valid),
        .rx_cpl_ready    (rx_cpl_ready),
        .rx_cpl          (rx_cpl),
        .req_seen        (req_seen),
        .req_split       (req_split),
        .hold            (hold),
        .timed_out       (cpl_timed_out)
    );

    always #2 clk = ~clk;

    // The AFU side drops its response ready now and then
    always @(negedge clk)
    begin
        afu_rd_rsp_ready <= ($urandom % 4) != 0;
    end

    // ======================================================================
    // Failure reporting
    // ======================================================================

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected)
        begin
            $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
                     $time, name, got, expected);
            report_failure($sformatf("%s has a wrong value", name));
        end
    endtask

    // Each dword of host memory holds its own byte address
    function automatic logic [127:0] line_payload(input logic [ADDR_W-1:0] addr, input int idx);
        logic [127:0] data;
        for (int k = 0; k < LINE_DWORDS; k++)
        begin
            data[32*k +: 32] = addr + 32'(LINE_BYTES * idx + 4 * k);
        end
        return data;
    endfunction

    // ======================================================================
    // Monitors for both DUT output streams
    // ======================================================================

    task automatic check_response();
        int a;
        int idx;
        a = int'(afu_rd_rsp.afu_tag);
        if (!tag_active[a])
        begin
            report_failure($sformatf("response for AFU tag 0x%0h with no open request", a));
        end
        idx = next_idx[a];
        check_value("afu_rd_rsp.line_idx", afu_rd_rsp.line_idx, idx);
        check_value("afu_rd_rsp.last", afu_rd_rsp.last, idx == exp_lines[a] - 1);
        check_value("afu_rd_rsp.payload", afu_rd_rsp.payload, line_payload(exp_addr[a], idx));
        next_idx[a] = idx + 1;
        rsp_count++;

        // The final line closes the request and returns its PCIe tag
        if (idx == exp_lines[a] - 1)
        begin
            tag_active[a] = 1'b0;
            tag_busy[pcie_of_afu[a]] = 1'b0;
        end
    endtask

    task automatic check_tlp();
        int a;
        if (issued_afu_q.size() == 0)
        begin
            report_failure("read TLP issued with no pending request");
        end
        a = issued_afu_q.pop_front();
        check_value("tx_rd_tlp.fmttype", tx_rd_tlp.fmttype, MEM_RD32);
        check_value("tx_rd_tlp.addr", tx_rd_tlp.addr, exp_addr[a]);
        check_value("tx_rd_tlp.length", tx_rd_tlp.length, exp_lines[a] * LINE_DWORDS);
        check_value("tx_rd_tlp.first_be", tx_rd_tlp.first_be, 4'hf);
        check_value("tx_rd_tlp.last_be", tx_rd_tlp.last_be, 4'hf);
        if (tag_busy[tx_rd_tlp.tag])
        begin
            report_failure($sformatf("PCIe tag %0d reissued while outstanding", tx_rd_tlp.tag));
        end
        tag_busy[tx_rd_tlp.tag] = 1'b1;
        pcie_of_afu[a] = tx_rd_tlp.tag;
        tx_count++;
    endtask

    // Responses are handled first so a tag freed on this edge counts as free
    always @(posedge clk)
    begin
        if (reset_n && afu_rd_rsp_valid && afu_rd_rsp_ready)
        begin
            check_response();
        end
        if (reset_n && tx_rd_tlp_valid && tx_rd_tlp_ready)
        begin
            check_tlp();
        end
        if (cpl_timed_out)
        begin
            report_failure("host model timed out on the completion stream");
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================

    task automatic read_cases();
        int fd;
        int r;
        string line;
        logic [ADDR_W-1:0] a;
        int l;
        int t;
        int s;
        int h;
        fd = $fopen("read_cases.txt", "r");
        if (fd == 0)
        begin
            report_failure("cannot open read_cases.txt");
        end
        num_cases = 0;
        while (!$feof(fd))
        begin
            line = "";
            r = $fgets(line, fd);
            if (r > 1 && line.getc(0) != "#")
            begin
                r = $sscanf(line, "%h %d %h %d %d", a, l, t, s, h);
                if (r == 5)
                begin
                    case_addr[num_cases] = a;
                    case_lines[num_cases] = l;
                    case_tag[num_cases] = t;
                    case_split[num_cases] = s;
                    case_hold[num_cases] = h;
                    num_cases++;
                end
            end
        end
        $fclose(fd);
        if (num_cases == 0)
        begin
            report_failure("read_cases.txt holds no cases");
        end
    endtask

    task automatic send_request(input int i);
        int a;
        int waited;
        @(negedge clk);
        a = case_tag[i];
        exp_addr[a] = case_addr[i];
        exp_lines[a] = case_lines[i];
        next_idx[a] = 0;
        tag_active[a] = 1'b1;
        afu_rd_req_valid = 1'b1;
        afu_rd_req.addr = case_addr[i];
        afu_rd_req.line_count = t_line_count'(case_lines[i]);
        afu_rd_req.afu_tag = AFU_TAG_W'(a);
        req_split = 3'(case_split[i]);
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                report_failure("timed out waiting for afu_rd_req ready");
            end
        end
        while (!afu_rd_req_ready);
        issued_afu_q.push_back(a);
        @(negedge clk);
        afu_rd_req_valid = 1'b0;
    endtask

    task automatic wait_responses(input int target);
        int waited;
        waited = 0;
        while (rsp_count < target)
        begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                report_failure("timed out waiting for read responses");
            end
        end
    endtask

    initial
    begin
        int snap_tx;
        int snap_rsp;
        int total_lines;
        void'($urandom(32'h1b7b_efe1));
        clk = 1'b0;
        reset_n = 1'b0;
        afu_rd_req_valid = 1'b0;
        afu_rd_req = '0;
        afu_rd_rsp_ready = 1'b0;
        req_split = 3'd1;
        hold = 1'b0;
        tx_count = 0;
        rsp_count = 0;
        snap_tx = 0;
        snap_rsp = 0;
        for (int i = 0; i < 256; i++)
        begin
            tag_active[i] = 1'b0;
        end
        for (int i = 0; i < NUM_TAGS; i++)
        begin
            tag_busy[i] = 1'b0;
        end
        read_cases();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        total_lines = 0;
        for (int i = 0; i < num_cases; i++)
        begin
            // A held group starts from an idle channel so all tags are free
            if (case_hold[i] != 0 && (i == 0 || case_hold[i-1] == 0))
            begin
                wait_responses(total_lines);
                @(negedge clk);
                hold = 1'b1;
                snap_tx = tx_count;
                snap_rsp = rsp_count;
            end
            send_request(i);
            total_lines += case_lines[i];

            // With no completions the tag pool must cap the TLPs in flight
            // Every tag was free when the group began, so each one gets used once
            if (case_hold[i] != 0 && (i == num_cases - 1 || case_hold[i+1] == 0))
            begin
                repeat (40) @(negedge clk);
                check_value("held read TLP count", tx_count - snap_tx, NUM_TAGS);
                if (rsp_count != snap_rsp)
                begin
                    report_failure("read response delivered while completions were held");
                end
                hold = 1'b0;
            end
        end
        wait_responses(total_lines);

        // A late or extra response would still show up in this window
        repeat (50) @(negedge clk);
        if (rsp_count != total_lines)
        begin
            report_failure("more read responses than requested lines");
        end
        else
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule
